// File: hw/avr_pkg.sv
/*
 * avr core package
 * widths, stage and instruction encodings, ALU select, status flag positions
 * and the decoded instruction and register write structs
 */
`default_nettype none

package avr_pkg;

    localparam int instr_width     = 16;
    localparam int data_width      = 8;
    localparam int pc_width        = 10;  // 1k instruction words
    localparam int reg_addr_width  = 4;
    localparam int port_addr_width = 6;
    localparam int reg_count       = 16;

    // one cycle each, wraps WB -> IF
    typedef enum logic [1:0] {
        stage_if = 2'd0,
        stage_id = 2'd1,
        stage_ex = 2'd2,
        stage_wb = 2'd3
    } stage_t;

    // value equals the top nibble of the instruction word
    typedef enum logic [3:0] {
        type_nop     = 4'h0,
        type_ldi     = 4'h1,
        type_mov     = 4'h2,
        type_add     = 4'h3,
        type_adc     = 4'h4,
        type_sub     = 4'h5,
        type_and     = 4'h6,
        type_or      = 4'h7,
        type_eor     = 4'h8,
        type_cp      = 4'h9,
        type_rjmp    = 4'ha,
        type_breq    = 4'hb,
        type_brne    = 4'hc,
        type_out     = 4'hd,
        type_illegal = 4'hf  // 4'he lands here too
    } instr_type_t;

    typedef enum logic [3:0] {
        op_none = 4'd0,
        op_add  = 4'd1,
        op_adc  = 4'd2,
        op_sub  = 4'd3,
        op_and  = 4'd4,
        op_or   = 4'd5,
        op_eor  = 4'd6,
        op_cp   = 4'd7,
        op_pass = 4'd8
    } opsel_t;

    // status register bit positions, AVR layout
    localparam int flag_c = 0;
    localparam int flag_z = 1;
    localparam int flag_n = 2;
    localparam int flag_v = 3;

    typedef struct packed {
        logic uses_alu;
        logic writes_reg;
        logic is_branch;
        logic is_out;
    } group_t;

    typedef struct packed {
        instr_type_t                 itype;
        logic [reg_addr_width-1:0]   rd;      // bits 11..8
        logic [reg_addr_width-1:0]   rr;      // bits 7..4
        logic [data_width-1:0]       imm;     // bits 7..0
        logic signed [data_width-1:0] offset; // bits 7..0, branch distance
        logic [port_addr_width-1:0]  port;    // bits 5..0
        group_t                      group;
    } decoded_t;

    typedef struct packed {
        logic                      we;
        logic [reg_addr_width-1:0] index;
        logic [data_width-1:0]     data;
    } reg_write_t;

endpackage

`default_nettype wire

// File: hw/decode_unit.sv
/*
 * instruction decoder
 * splits the buffered instruction word into fields, maps the top nibble
 * to an instruction type and sets the group flags used by the control unit
 */
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
    input  wire logic [avr_pkg::instr_width-1:0] instr,
    output avr_pkg::decoded_t                    decoded
);

    avr_pkg::instr_type_t itype;

    // unused opcode 4'he executes as a NOP
    always_comb begin
        if (instr[15:12] == 4'he) begin
            itype = avr_pkg::type_illegal;
        end else begin
            itype = avr_pkg::instr_type_t'(instr[15:12]);
        end
    end

    always_comb begin
        decoded.itype  = itype;
        decoded.rd     = instr[11:8];
        decoded.rr     = instr[7:4];
        decoded.imm    = instr[7:0];
        decoded.offset = instr[7:0];
        decoded.port   = instr[5:0];

        // everything that goes through the ALU, MOV included (pass)
        decoded.group.uses_alu = itype inside {
            avr_pkg::type_mov, avr_pkg::type_add, avr_pkg::type_adc,
            avr_pkg::type_sub, avr_pkg::type_and, avr_pkg::type_or,
            avr_pkg::type_eor, avr_pkg::type_cp
        };

        // CP is missing on purpose, flags only
        decoded.group.writes_reg = itype inside {
            avr_pkg::type_ldi, avr_pkg::type_mov, avr_pkg::type_add,
            avr_pkg::type_adc, avr_pkg::type_sub, avr_pkg::type_and,
            avr_pkg::type_or, avr_pkg::type_eor
        };

        decoded.group.is_branch = itype inside {
            avr_pkg::type_rjmp, avr_pkg::type_breq, avr_pkg::type_brne
        };

        decoded.group.is_out = (itype == avr_pkg::type_out);
    end

endmodule

`default_nettype wire

// File: hw/reg_file.sv
/*
 * register file
 * sixteen 8-bit registers, two combinational read ports, one clocked write port
 */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire logic                               clk,
    input  wire logic                               reset,
    input  wire logic [avr_pkg::reg_addr_width-1:0] rd_index,
    input  wire logic [avr_pkg::reg_addr_width-1:0] rr_index,
    output logic      [avr_pkg::data_width-1:0]     rd_value,
    output logic      [avr_pkg::data_width-1:0]     rr_value,
    input  avr_pkg::reg_write_t                     reg_write
);

    logic [avr_pkg::data_width-1:0] regs [avr_pkg::reg_count];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < avr_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_write.we) begin
            regs[reg_write.index] <= reg_write.data;
        end
    end

    // no bypass, writes land in WB and reads happen in the next ID
    assign rd_value = regs[rd_index];
    assign rr_value = regs[rr_index];

endmodule

`default_nettype wire

// File: hw/alu.sv
/*
 * 8-bit ALU
 * add, add with carry, subtract, compare, logic ops and pass,
 * with C, Z, N and V updated after AVR rules
 */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire logic                           enable,
    input  avr_pkg::opsel_t                     opsel,
    input  wire logic [avr_pkg::data_width-1:0] a,
    input  wire logic [avr_pkg::data_width-1:0] b,
    input  wire logic [avr_pkg::data_width-1:0] flags_in,
    output logic      [avr_pkg::data_width-1:0] result,
    output logic      [avr_pkg::data_width-1:0] flags_out
);

    logic [avr_pkg::data_width:0]   wide;  // msb is carry or borrow
    logic [avr_pkg::data_width-1:0] res;
    logic                           logic_op;
    logic                           is_sub;
    logic                           update;
    logic                           sign_a;
    logic                           sign_b;
    logic                           sign_r;
    logic                           ovf;

    always_comb begin
        wide     = '0;
        logic_op = 1'b0;
        update   = 1'b1;
        case (opsel)
            avr_pkg::op_add: wide = {1'b0, a} + {1'b0, b};
            avr_pkg::op_adc: wide = {1'b0, a} + {1'b0, b} + flags_in[avr_pkg::flag_c];
            avr_pkg::op_sub,
            avr_pkg::op_cp: wide = {1'b0, a} - {1'b0, b};  // msb set when a < b
            avr_pkg::op_and: begin
                wide     = {1'b0, a & b};
                logic_op = 1'b1;
            end
            avr_pkg::op_or: begin
                wide     = {1'b0, a | b};
                logic_op = 1'b1;
            end
            avr_pkg::op_eor: begin
                wide     = {1'b0, a ^ b};
                logic_op = 1'b1;
            end
            avr_pkg::op_pass: begin
                wide   = {1'b0, b};  // MOV, flags untouched
                update = 1'b0;
            end
            default: update = 1'b0;
        endcase
    end

    assign res    = wide[avr_pkg::data_width-1:0];
    assign is_sub = opsel inside {avr_pkg::op_sub, avr_pkg::op_cp};
    assign sign_a = a[avr_pkg::data_width-1];
    assign sign_b = b[avr_pkg::data_width-1];
    assign sign_r = res[avr_pkg::data_width-1];
    // two's complement overflow, operand signs differ for subtract
    assign ovf    = (is_sub ? (sign_a ^ sign_b) : ~(sign_a ^ sign_b)) & (sign_r ^ sign_a);

    always_comb begin
        flags_out = flags_in;
        if (enable && update) begin
            flags_out[avr_pkg::flag_z] = (res == '0);
            flags_out[avr_pkg::flag_n] = sign_r;
            if (logic_op) begin
                flags_out[avr_pkg::flag_v] = 1'b0;  // C kept
            end else begin
                flags_out[avr_pkg::flag_c] = wide[avr_pkg::data_width];
                flags_out[avr_pkg::flag_v] = ovf;
            end
        end
    end

    assign result = enable ? res : '0;

endmodule

`default_nettype wire

// File: hw/control_unit.sv
/*
 * control unit
 * steps IF, ID, EX, WB, holds the program counter, status register and the
 * instruction, operand and ALU buffers, and drives writeback and port writes
 */
`timescale 1ns/1ps
`default_nettype none

module control_unit (
    input  wire logic                                clk,
    input  wire logic                                reset,
    // program ROM
    output logic      [avr_pkg::pc_width-1:0]        prog_addr,
    input  wire logic [avr_pkg::instr_width-1:0]     prog_data,
    // decoder
    output logic      [avr_pkg::instr_width-1:0]     instr,
    input  avr_pkg::decoded_t                        decoded,
    // register file
    output logic      [avr_pkg::reg_addr_width-1:0]  rd_index,
    output logic      [avr_pkg::reg_addr_width-1:0]  rr_index,
    input  wire logic [avr_pkg::data_width-1:0]      rd_value,
    input  wire logic [avr_pkg::data_width-1:0]      rr_value,
    output avr_pkg::reg_write_t                      reg_write,
    // ALU
    output logic                                     alu_enable,
    output avr_pkg::opsel_t                          alu_opsel,
    output logic      [avr_pkg::data_width-1:0]      alu_a,
    output logic      [avr_pkg::data_width-1:0]      alu_b,
    output logic      [avr_pkg::data_width-1:0]      alu_flags_in,
    input  wire logic [avr_pkg::data_width-1:0]      alu_result,
    input  wire logic [avr_pkg::data_width-1:0]      alu_flags_out,
    // output port
    output logic                                     port_we,
    output logic      [avr_pkg::port_addr_width-1:0] port_addr,
    output logic      [avr_pkg::data_width-1:0]      port_data
);

    avr_pkg::stage_t                stage;
    logic [avr_pkg::pc_width-1:0]   pc;
    logic [avr_pkg::instr_width-1:0] instr_buf;
    logic [avr_pkg::data_width-1:0] op_a;     // rd value
    logic [avr_pkg::data_width-1:0] op_b;     // rr value or LDI immediate
    logic [avr_pkg::data_width-1:0] alu_buf;
    logic [avr_pkg::data_width-1:0] sreg;
    logic [avr_pkg::pc_width-1:0]   offset_ext;
    logic                           taken;

    // two-bit counter, wraps from WB back to IF
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stage <= avr_pkg::stage_if;
        end else begin
            stage <= avr_pkg::stage_t'(stage + 2'd1);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            instr_buf <= '0;
        end else if (stage == avr_pkg::stage_if) begin
            instr_buf <= prog_data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            op_a <= '0;
            op_b <= '0;
        end else if (stage == avr_pkg::stage_id) begin
            op_a <= rd_value;
            if (decoded.itype == avr_pkg::type_ldi) begin
                op_b <= decoded.imm;
            end else begin
                op_b <= rr_value;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            alu_buf <= '0;
            sreg    <= '0;
        end else if (stage == avr_pkg::stage_ex) begin
            alu_buf <= alu_result;
            if (decoded.group.uses_alu) begin
                sreg <= alu_flags_out;
            end
        end
    end

    // branch decision on Z, RJMP always goes
    always_comb begin
        case (decoded.itype)
            avr_pkg::type_breq: taken = sreg[avr_pkg::flag_z];
            avr_pkg::type_brne: taken = !sreg[avr_pkg::flag_z];
            default:            taken = 1'b1;
        endcase
        taken = taken && decoded.group.is_branch;
    end

    assign offset_ext = {{(avr_pkg::pc_width - avr_pkg::data_width){decoded.offset[7]}},
                         decoded.offset};

    // offset added in EX, the WB increment follows, so target is pc + k + 1
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else if (stage == avr_pkg::stage_ex && taken) begin
            pc <= pc + offset_ext;
        end else if (stage == avr_pkg::stage_wb) begin
            pc <= pc + 1'b1;
        end
    end

    always_comb begin
        case (decoded.itype)
            avr_pkg::type_add: alu_opsel = avr_pkg::op_add;
            avr_pkg::type_adc: alu_opsel = avr_pkg::op_adc;
            avr_pkg::type_sub: alu_opsel = avr_pkg::op_sub;
            avr_pkg::type_and: alu_opsel = avr_pkg::op_and;
            avr_pkg::type_or:  alu_opsel = avr_pkg::op_or;
            avr_pkg::type_eor: alu_opsel = avr_pkg::op_eor;
            avr_pkg::type_cp:  alu_opsel = avr_pkg::op_cp;    // subtract, no writeback
            avr_pkg::type_mov: alu_opsel = avr_pkg::op_pass;
            default:           alu_opsel = avr_pkg::op_none;
        endcase
        if (!alu_enable) begin
            alu_opsel = avr_pkg::op_none;
        end
    end

    assign alu_enable   = (stage == avr_pkg::stage_ex) && decoded.group.uses_alu;
    assign alu_a        = op_a;
    assign alu_b        = op_b;
    assign alu_flags_in = sreg;

    always_comb begin
        reg_write.we    = (stage == avr_pkg::stage_wb) && decoded.group.writes_reg;
        reg_write.index = decoded.rd;
        reg_write.data  = (decoded.itype == avr_pkg::type_ldi) ? op_b : alu_buf;
    end

    // OUT sends rd, one cycle strobe in WB
    assign port_we   = (stage == avr_pkg::stage_wb) && decoded.group.is_out;
    assign port_addr = decoded.port;
    assign port_data = op_a;

    assign prog_addr = pc;
    assign instr     = instr_buf;
    assign rd_index  = decoded.rd;
    assign rr_index  = decoded.rr;

endmodule

`default_nettype wire

// File: hw/avr_core.sv
/*
 * avr core top level
 * ties the control unit to the decoder, register file and ALU
 */
`timescale 1ns/1ps
`default_nettype none

module avr_core (
    input  wire logic                                clk,
    input  wire logic                                reset,
    output logic      [avr_pkg::pc_width-1:0]        prog_addr,
    input  wire logic [avr_pkg::instr_width-1:0]     prog_data,
    output logic                                     port_we,
    output logic      [avr_pkg::port_addr_width-1:0] port_addr,
    output logic      [avr_pkg::data_width-1:0]      port_data
);

    logic [avr_pkg::instr_width-1:0]    instr;
    avr_pkg::decoded_t                  decoded;
    logic [avr_pkg::reg_addr_width-1:0] rd_index;
    logic [avr_pkg::reg_addr_width-1:0] rr_index;
    logic [avr_pkg::data_width-1:0]     rd_value;
    logic [avr_pkg::data_width-1:0]     rr_value;
    avr_pkg::reg_write_t                reg_write;
    logic                               alu_enable;
    avr_pkg::opsel_t                    alu_opsel;
    logic [avr_pkg::data_width-1:0]     alu_a;
    logic [avr_pkg::data_width-1:0]     alu_b;
    logic [avr_pkg::data_width-1:0]     alu_flags_in;
    logic [avr_pkg::data_width-1:0]     alu_result;
    logic [avr_pkg::data_width-1:0]     alu_flags_out;

    control_unit i_control_unit (
        .clk          (clk),
        .reset        (reset),
        .prog_addr    (prog_addr),
        .prog_data    (prog_data),
        .instr        (instr),
        .decoded      (decoded),
        .rd_index     (rd_index),
        .rr_index     (rr_index),
        .rd_value     (rd_value),
        .rr_value     (rr_value),
        .reg_write    (reg_write),
        .alu_enable   (alu_enable),
        .alu_opsel    (alu_opsel),
        .alu_a        (alu_a),
        .alu_b        (alu_b),
        .alu_flags_in (alu_flags_in),
        .alu_result   (alu_result),
        .alu_flags_out(alu_flags_out),
        .port_we      (port_we),
        .port_addr    (port_addr),
        .port_data    (port_data)
    );

    decode_unit i_decode_unit (
        .instr  (instr),
        .decoded(decoded)
    );

    reg_file i_reg_file (
        .clk      (clk),
        .reset    (reset),
        .rd_index (rd_index),
        .rr_index (rr_index),
        .rd_value (rd_value),
        .rr_value (rr_value),
        .reg_write(reg_write)
    );

    alu i_alu (
        .enable   (alu_enable),
        .opsel    (alu_opsel),
        .a        (alu_a),
        .b        (alu_b),
        .flags_in (alu_flags_in),
        .result   (alu_result),
        .flags_out(alu_flags_out)
    );

endmodule

`default_nettype wire

// File: testbench/avr_core_asserts.sv
/*
 * protocol checks bound to the core top level
 * strobe width, strobe position in the instruction, pc movement, reset quiet
 */
`timescale 1ns/1ps
`default_nettype none

module avr_core_asserts (
    input wire logic                                clk,
    input wire logic                                reset,
    input wire logic [avr_pkg::pc_width-1:0]        prog_addr,
    input wire logic                                port_we,
    input wire logic [avr_pkg::port_addr_width-1:0] port_addr,
    input wire logic [avr_pkg::data_width-1:0]      port_data
);

    int                           fail_count = 0;
    logic [avr_pkg::pc_width-1:0] last_addr;
    logic [2:0]                   move_hist;  // bit 2 is three cycles back
    logic                         moved;

    assign moved = (prog_addr != last_addr);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            last_addr <= '0;
            move_hist <= '0;
        end else begin
            last_addr <= prog_addr;
            move_hist <= {move_hist[1:0], moved};
        end
    end

    strobe_width: assert property (@(posedge clk) disable iff (reset) port_we |=> !port_we)
        else begin
            fail_count++;
            $error("port_we stayed high for more than one cycle");
        end

    // pc moves when IF starts, so WB is the fourth cycle after that move
    strobe_in_wb: assert property (@(posedge clk) disable iff (reset)
        port_we |-> {move_hist, moved} == 4'b1000)
        else begin
            fail_count++;
            $error("port_we outside the fourth cycle of an instruction");
        end

    pc_moves: assert property (@(posedge clk) disable iff (reset)
        $countones({move_hist, moved}) <= 2)
        else begin
            fail_count++;
            $error("prog_addr changed more than twice in four cycles");
        end

    quiet_in_reset: assert property (@(posedge clk) reset |=> !reset ||
        (!port_we && $stable(prog_addr) && $stable(port_addr) && $stable(port_data)))
        else begin
            fail_count++;
            $error("core outputs toggled while reset was held");
        end

endmodule

bind avr_core avr_core_asserts i_avr_core_asserts (
    .clk      (clk),
    .reset    (reset),
    .prog_addr(prog_addr),
    .port_we  (port_we),
    .port_addr(port_addr),
    .port_data(port_data)
);

`default_nettype wire

// File: testbench/tb_avr_core.sv
/*
 * testbench for the avr core
 * ROM model with a fixed program and an LCG block, reference model of the
 * ISA, and port write checks against the expected sequence
 */
`timescale 1ns/1ps
`default_nettype none

module tb_avr_core;

    localparam int timeout_cycles = 2000;
    localparam int rom_depth      = 1 << avr_pkg::pc_width;

    logic                                clk;
    logic                                reset;
    logic [avr_pkg::pc_width-1:0]        prog_addr;
    logic [avr_pkg::instr_width-1:0]     prog_data;
    logic                                port_we;
    logic [avr_pkg::port_addr_width-1:0] port_addr;
    logic [avr_pkg::data_width-1:0]      port_data;

    logic [15:0] rom [rom_depth];
    logic [5:0]  exp_addr [256];
    logic [7:0]  exp_data [256];
    logic [5:0]  next_addr;
    logic [7:0]  next_data;
    int          exp_count;
    int          wr_count;
    int          load_ptr;
    int          halt_pc;
    int          port_errors  = 0;
    int          other_errors = 0;
    int unsigned rng;

    avr_core i_avr_core (
        .clk      (clk),
        .reset    (reset),
        .prog_addr(prog_addr),
        .prog_data(prog_data),
        .port_we  (port_we),
        .port_addr(port_addr),
        .port_data(port_data)
    );

    assign prog_data = rom[prog_addr];  // combinational ROM
    assign next_addr = exp_addr[wr_count[7:0]];
    assign next_data = exp_data[wr_count[7:0]];

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_count <= 0;
        end else if (port_we) begin
            wr_count <= wr_count + 1;
        end
    end

    addr_check: assert property (@(posedge clk) disable iff (reset)
        port_we |-> port_addr == next_addr)
        else begin
            port_errors++;
            $display("FAILED port_addr: got %h expected %h", $sampled(port_addr),
                     $sampled(next_addr));
        end

    data_check: assert property (@(posedge clk) disable iff (reset)
        port_we |-> port_data == next_data)
        else begin
            port_errors++;
            $display("FAILED port_data: got %h expected %h", $sampled(port_data),
                     $sampled(next_data));
        end

    overrun_check: assert property (@(posedge clk) disable iff (reset)
        port_we |-> wr_count < exp_count)
        else begin
            port_errors++;
            $display("port write seen after all %0d expected writes", exp_count);
        end

    function automatic int unsigned lcg_next(input int unsigned state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [15:0] reg_form(input logic [3:0] op, input logic [3:0] d,
                                             input logic [3:0] r);
        return {op, d, r, 4'h0};
    endfunction

    function automatic logic [15:0] imm_form(input logic [3:0] op, input logic [3:0] d,
                                             input logic [7:0] k);
        return {op, d, k};
    endfunction

    function automatic logic [15:0] out_form(input logic [3:0] d, input logic [5:0] port);
        return {avr_pkg::type_out, d, 2'b00, port};
    endfunction

    function automatic logic [15:0] jump_form(input logic [3:0] op, input logic [7:0] k);
        return {op, 4'h0, k};
    endfunction

    task automatic emit(input logic [15:0] word);
        rom[load_ptr] = word;
        load_ptr++;
    endtask

    task automatic build_program();
        logic [3:0] op;
        logic [3:0] d;
        logic [3:0] r;
        foreach (rom[i]) begin
            rom[i] = 16'h0000;
        end
        load_ptr = 0;
        emit(imm_form(avr_pkg::type_ldi, 4'd0, 8'h5a));
        emit(out_form(4'd0, 6'h01));
        emit(imm_form(avr_pkg::type_ldi, 4'd1, 8'hf0));
        emit(imm_form(avr_pkg::type_ldi, 4'd2, 8'h20));
        emit(reg_form(avr_pkg::type_add, 4'd1, 4'd2));  // overflows, sets carry
        emit(reg_form(avr_pkg::type_adc, 4'd2, 4'd0));
        emit(out_form(4'd1, 6'h02));
        emit(out_form(4'd2, 6'h03));
        emit(reg_form(avr_pkg::type_cp, 4'd1, 4'd1));
        emit(jump_form(avr_pkg::type_breq, 8'h01));
        emit(out_form(4'd0, 6'h3e));                    // skipped
        emit(jump_form(avr_pkg::type_brne, 8'h01));
        emit(out_form(4'd1, 6'h04));
        emit(imm_form(avr_pkg::type_ldi, 4'd3, 8'h03));  // loop count
        emit(imm_form(avr_pkg::type_ldi, 4'd4, 8'h01));
        emit(imm_form(avr_pkg::type_ldi, 4'd5, 8'h00));
        emit(out_form(4'd3, 6'h05));
        emit(reg_form(avr_pkg::type_sub, 4'd3, 4'd4));
        emit(jump_form(avr_pkg::type_breq, 8'h01));
        emit(jump_form(avr_pkg::type_rjmp, 8'hfc));     // back to the loop OUT
        emit(out_form(4'd5, 6'h06));
        for (int i = 0; i < 24; i++) begin
            rng = lcg_next(rng);
            op  = 4'(1 + rng[23:20] % 9);  // LDI up to CP
            d   = {1'b0, rng[18:16]};
            r   = {1'b0, rng[14:12]};
            if (op == avr_pkg::type_ldi) begin
                emit(imm_form(op, d, rng[31:24]));
            end else begin
                emit(reg_form(op, d, r));
            end
            emit(out_form(d, rng[29:24]));
        end
        emit(jump_form(avr_pkg::type_rjmp, 8'hff));     // halt on itself
    endtask

    task automatic run_model();
        logic [7:0]  regs [16];
        logic [15:0] ins;
        logic [8:0]  wide;
        logic [7:0]  a;
        logic [7:0]  b;
        logic [3:0]  d;
        logic [3:0]  op;
        logic        carry;
        logic        zero;
        int          pc;
        int          steps;
        foreach (regs[i]) begin
            regs[i] = '0;
        end
        foreach (exp_addr[i]) begin
            exp_addr[i] = '0;
            exp_data[i] = '0;
        end
        carry     = 1'b0;
        zero      = 1'b0;
        pc        = 0;
        steps     = 0;
        exp_count = 0;
        while (rom[pc] != 16'ha0ff && steps < timeout_cycles) begin
            ins = rom[pc];
            op  = ins[15:12];
            d   = ins[11:8];
            a   = regs[d];
            b   = regs[ins[7:4]];
            pc  = pc + 1;
            steps++;
            case (op)
                avr_pkg::type_ldi: regs[d] = ins[7:0];
                avr_pkg::type_mov: regs[d] = b;
                avr_pkg::type_add, avr_pkg::type_adc: begin
                    wide    = {1'b0, a} + {1'b0, b} + ((op == avr_pkg::type_adc) ? carry : 1'b0);
                    carry   = wide[8];
                    zero    = (wide[7:0] == 8'h00);
                    regs[d] = wide[7:0];
                end
                avr_pkg::type_sub, avr_pkg::type_cp: begin
                    wide  = {1'b0, a} - {1'b0, b};
                    carry = wide[8];  // borrow
                    zero  = (wide[7:0] == 8'h00);
                    if (op == avr_pkg::type_sub) begin
                        regs[d] = wide[7:0];
                    end
                end
                avr_pkg::type_and, avr_pkg::type_or, avr_pkg::type_eor: begin
                    regs[d] = (op == avr_pkg::type_and) ? (a & b) :
                              (op == avr_pkg::type_or)  ? (a | b) : (a ^ b);
                    zero    = (regs[d] == 8'h00);
                end
                avr_pkg::type_rjmp: pc = pc + int'($signed(ins[7:0]));
                avr_pkg::type_breq: pc = zero ? pc + int'($signed(ins[7:0])) : pc;
                avr_pkg::type_brne: pc = !zero ? pc + int'($signed(ins[7:0])) : pc;
                avr_pkg::type_out: begin
                    exp_addr[exp_count] = ins[5:0];
                    exp_data[exp_count] = a;
                    exp_count++;
                end
                default: ;
            endcase
        end
        halt_pc = pc;
    endtask

    task automatic wait_for_halt();
        int cycles;
        cycles = 0;
        while (prog_addr !== halt_pc[avr_pkg::pc_width-1:0] && cycles < timeout_cycles) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (prog_addr !== halt_pc[avr_pkg::pc_width-1:0]) begin
            other_errors++;
            $display("timeout while waiting for the core to reach the halt loop");
        end
    endtask

    initial begin
        reset = 1'b0;
        rng   = 50;
        build_program();
        run_model();
        #1;
        reset = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        reset_check: assert (prog_addr == '0)
            else begin
                other_errors++;
                $display("FAILED prog_addr: got %h expected %h", prog_addr, 10'h000);
            end
        wait_for_halt();
        count_check: assert (wr_count == exp_count)
            else begin
                other_errors++;
                $display("FAILED wr_count: got %h expected %h", wr_count, exp_count);
            end
        $display("errors: port checks %0d, other checks %0d, bound assertions %0d",
                 port_errors, other_errors, i_avr_core.i_avr_core_asserts.fail_count);
        if (port_errors + other_errors + i_avr_core.i_avr_core_asserts.fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: avr_core.f
hw/avr_pkg.sv
hw/decode_unit.sv
hw/reg_file.sv
hw/alu.sv
hw/control_unit.sv
hw/avr_core.sv
testbench/avr_core_asserts.sv
testbench/tb_avr_core.sv

// File: Bender.yml
package:
  name: avr_core

sources:
  - files:
      - hw/avr_pkg.sv
      - hw/decode_unit.sv
      - hw/reg_file.sv
      - hw/alu.sv
      - hw/control_unit.sv
      - hw/avr_core.sv
  - target: test
    files:
      - testbench/avr_core_asserts.sv
      - testbench/tb_avr_core.sv
